/* source/pitaya_pkg.sv */
package pitaya_pkg;

  ////////////////////
  // sizes
  ////////////////////

  // analog channels, shared by ADC and DAC
  localparam int NCH = 2;
  // raw converter word
  localparam int ADC_RAW_W = 16;
  localparam int SMP_W = 14;
  localparam int MUL_W = 16;
  // 16384 is unity gain
  localparam int GAIN_SHIFT = 14;
  // saturation limits for a 14 bit sample
  localparam int SMP_MAX = 8191;
  localparam int SMP_MIN = -8192;

  ////////////////////
  // register map
  ////////////////////

  localparam logic [3:0] REG_CTL = 4'd0;
  // one register per channel from here on
  localparam logic [3:0] REG_ADC_CAL0 = 4'd1;
  localparam logic [3:0] REG_DAC_CAL0 = 4'd3;

  typedef logic signed [SMP_W-1:0] smp_t;

  // gain and offset word
  typedef struct packed {
    logic signed [MUL_W-1:0] mul;
    logic [1:0] rsv;
    logic signed [SMP_W-1:0] sum;
  } cal_t;

  // control word, loopback enable per channel
  typedef struct packed {
    logic [32-NCH-1:0] rsv;
    logic [NCH-1:0] loop;
  } ctl_t;

  // write data, meaning depends on address
  typedef union packed {
    cal_t cal;
    ctl_t ctl;
  } cfg_data_u;

  typedef struct packed {
    logic en;
    logic [3:0] addr;
    cfg_data_u data;
  } cfg_wr_t;

  // sample stream, no back-pressure
  typedef struct packed {
    logic vld;
    smp_t [NCH-1:0] dat;
  } smp_stream_t;

  typedef struct packed {
    logic pos;
    logic neg;
  } trg_t;

endpackage

/* source/calib_regs.sv */
`timescale 1ns/100ps

module calib_regs import pitaya_pkg::*; (
  input  logic adc_clk,
  input  logic top_rst,
  // register write port
  input  cfg_wr_t cfg_i,
  // settings
  output cal_t [NCH-1:0] adc_cal_o,
  output cal_t [NCH-1:0] dac_cal_o,
  output logic [NCH-1:0] loop_o
);

  // unity gain, no offset
  localparam cal_t CAL_RST = '{mul: MUL_W'(1 << GAIN_SHIFT), rsv: 2'b00, sum: '0};

  logic ctl_hit;
  logic [NCH-1:0] adc_hit;
  logic [NCH-1:0] dac_hit;

  ////////////////////
  // address decode
  ////////////////////

  always_comb begin
    ctl_hit = cfg_i.en && (cfg_i.addr == REG_CTL);
    for (int i = 0; i < NCH; i++) begin
      // one register per channel
      adc_hit[i] = cfg_i.en && (cfg_i.addr == REG_ADC_CAL0 + 4'(i));
      dac_hit[i] = cfg_i.en && (cfg_i.addr == REG_DAC_CAL0 + 4'(i));
    end
  end

  ////////////////////
  // register file
  ////////////////////

  // unmapped addresses hit nothing
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_cal_o <= {NCH{CAL_RST}};
      dac_cal_o <= {NCH{CAL_RST}};
      loop_o <= '0;
    end else begin
      // control word view of the data
      if (ctl_hit) begin
        loop_o <= cfg_i.data.ctl.loop;
      end
      // calibration view of the same data
      for (int i = 0; i < NCH; i++) begin
        if (adc_hit[i]) begin
          adc_cal_o[i] <= cfg_i.data.cal;
        end
        if (dac_hit[i]) begin
          dac_cal_o[i] <= cfg_i.data.cal;
        end
      end
    end
  end

endmodule

/* source/linear_cal.sv */
`timescale 1ns/100ps

module linear_cal import pitaya_pkg::*; (
  input  logic adc_clk,
  input  logic top_rst,
  // sample stream in
  input  smp_stream_t s_i,
  // gain and offset per channel
  input  cal_t [NCH-1:0] cal_i,
  // calibrated stream out
  output smp_stream_t s_o
);

  // full product, and the shifted sum with one guard bit
  localparam int PRD_W = SMP_W + MUL_W;
  localparam int SUM_W = PRD_W - GAIN_SHIFT + 1;

  logic vld1_q;
  logic vld2_q;
  logic signed [PRD_W-1:0] prd_q [NCH];
  logic signed [SUM_W-1:0] acc [NCH];
  smp_t [NCH-1:0] sat;
  smp_t [NCH-1:0] dat_q;

  // valid follows the data through both stages
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld1_q <= 1'b0;
      vld2_q <= 1'b0;
    end else begin
      vld1_q <= s_i.vld;
      vld2_q <= vld1_q;
    end
  end

  ////////////////////
  // stage 1 multiply
  ////////////////////

  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < NCH; i++) begin
      if (s_i.vld) begin
        prd_q[i] <= $signed(s_i.dat[i]) * $signed(cal_i[i].mul);
      end
      // stage 2 register, saturated sum
      if (vld1_q) begin
        dat_q[i] <= sat[i];
      end
    end
  end

  ////////////////////
  // stage 2 offset
  ////////////////////

  always_comb begin
    for (int i = 0; i < NCH; i++) begin
      // scale back, then add offset
      acc[i] = SUM_W'(prd_q[i] >>> GAIN_SHIFT) + SUM_W'($signed(cal_i[i].sum));
      // clamp to sample range
      if (acc[i] > SMP_MAX) begin
        sat[i] = SMP_W'(SMP_MAX);
      end else if (acc[i] < SMP_MIN) begin
        sat[i] = SMP_W'(SMP_MIN);
      end else begin
        sat[i] = acc[i][SMP_W-1:0];
      end
    end
  end

  assign s_o = {vld2_q, dat_q};

endmodule

/* source/adc_frontend.sv */
`timescale 1ns/100ps

module adc_frontend import pitaya_pkg::*; (
  input  logic adc_clk,
  input  logic top_rst,
  // converter pins
  input  logic [NCH-1:0][ADC_RAW_W-1:0] adc_dat_i,
  // loopback enable per channel
  input  logic [NCH-1:0] loop_i,
  // calibrated DAC stream for loopback
  input  smp_stream_t dac_cal_i,
  // selected stream toward calibration
  output smp_stream_t adc_sel_o
);

  logic adc_vld_q;
  smp_t [NCH-1:0] adc_q;

  // converter runs freely, valid once out of reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_vld_q <= 1'b0;
    end else begin
      adc_vld_q <= 1'b1;
    end
  end

  // input register, low two bits dropped
  // sign kept, rest inverted
  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < NCH; i++) begin
      adc_q[i] <= {adc_dat_i[i][ADC_RAW_W-1], ~adc_dat_i[i][ADC_RAW_W-2 -: SMP_W-1]};
    end
  end

  ////////////////////
  // loopback select
  ////////////////////

  always_comb begin
    // invalid if any looped channel lacks DAC data
    adc_sel_o.vld = adc_vld_q & ~|(loop_i & {NCH{~dac_cal_i.vld}});
    for (int i = 0; i < NCH; i++) begin
      adc_sel_o.dat[i] = loop_i[i] ? dac_cal_i.dat[i] : adc_q[i];
    end
  end

endmodule

/* source/dac_backend.sv */
`timescale 1ns/100ps

module dac_backend import pitaya_pkg::*; (
  input  logic adc_clk,
  input  logic top_rst,
  // calibrated samples
  input  smp_stream_t s_i,
  // converter pins
  output logic [NCH-1:0][SMP_W-1:0] dac_dat_o,
  output logic dac_rst_o
);

  logic [NCH-1:0][SMP_W-1:0] code;

  // signed to negative slope unsigned
  always_comb begin
    for (int i = 0; i < NCH; i++) begin
      code[i] = {s_i.dat[i][SMP_W-1], ~s_i.dat[i][SMP_W-2:0]};
    end
  end

  // output register, holds last word without valid
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= '0;
    end else if (s_i.vld) begin
      dac_dat_o <= code;
    end
  end

  // converter reset, released one edge after top reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_rst_o <= 1'b1;
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

endmodule

/* source/gpio_debounce.sv */
`timescale 1ns/100ps

module gpio_debounce import pitaya_pkg::*; #(
  // counter width
  parameter int unsigned CW = 20,
  // stable cycles before a change is taken
  parameter int unsigned LEN = 62500
) (
  input  logic adc_clk,
  input  logic top_rst,
  // raw pin
  input  logic d_i,
  // edge pulses
  output trg_t trg_o
);

  logic [1:0] sync_q;
  logic lvl_q;
  logic [CW-1:0] cnt_q;

  // two flop synchronizer, bit 1 is safe
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], d_i};
    end
  end

  ////////////////////
  // stability count
  ////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      lvl_q <= 1'b0;
      cnt_q <= '0;
      trg_o <= '0;
    end else begin
      // pulses last one cycle
      trg_o <= '0;
      if (sync_q[1] == lvl_q) begin
        // input agrees, restart count
        cnt_q <= '0;
      end else if (cnt_q == CW'(LEN - 1)) begin
        // LEN differing cycles, take new level
        cnt_q <= '0;
        lvl_q <= sync_q[1];
        trg_o.pos <= sync_q[1];
        trg_o.neg <= ~sync_q[1];
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

/* source/analog_top.sv */
`timescale 1ns/100ps

module analog_top import pitaya_pkg::*; #(
  // debounce counter width and length, 0.5 ms at 125 MHz
  parameter int unsigned DEB_CW = 20,
  parameter int unsigned DEB_LEN = 62500
) (
  input  logic adc_clk,
  input  logic top_rst,
  // register write port
  input  cfg_wr_t cfg_i,
  // ADC pins
  input  logic [NCH-1:0][ADC_RAW_W-1:0] adc_dat_i,
  // generator stream toward DAC
  input  smp_stream_t dac_i,
  // expansion pin for the trigger
  input  logic exp_i,
  // acquired stream
  output smp_stream_t acq_o,
  // DAC pins, both channels in parallel
  output logic [NCH-1:0][SMP_W-1:0] dac_dat_o,
  output logic dac_rst_o,
  output trg_t trg_o
);

  cal_t [NCH-1:0] adc_cal;
  cal_t [NCH-1:0] dac_cal_cfg;
  logic [NCH-1:0] loop;
  // calibrated DAC stream, also the loopback source
  smp_stream_t dac_cal;
  // ADC or loopback samples before calibration
  smp_stream_t adc_sel;

  ////////////////////
  // settings
  ////////////////////

  calib_regs regs (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .cfg_i     (cfg_i),
    .adc_cal_o (adc_cal),
    .dac_cal_o (dac_cal_cfg),
    .loop_o    (loop)
  );

  ////////////////////
  // ADC path
  ////////////////////

  adc_frontend frontend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .loop_i    (loop),
    .dac_cal_i (dac_cal),
    .adc_sel_o (adc_sel)
  );

  linear_cal adc_lin (.adc_clk (adc_clk), .top_rst (top_rst), .s_i (adc_sel),
                      .cal_i (adc_cal), .s_o (acq_o));

  ////////////////////
  // DAC path
  ////////////////////

  linear_cal dac_lin (.adc_clk (adc_clk), .top_rst (top_rst), .s_i (dac_i),
                      .cal_i (dac_cal_cfg), .s_o (dac_cal));

  dac_backend backend (.adc_clk (adc_clk), .top_rst (top_rst), .s_i (dac_cal),
                       .dac_dat_o (dac_dat_o), .dac_rst_o (dac_rst_o));

  // trigger from expansion pin
  gpio_debounce #(.CW (DEB_CW), .LEN (DEB_LEN)) debounce (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .d_i     (exp_i),
    .trg_o   (trg_o)
  );

endmodule

/* verification/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen #(
  parameter int PERIOD_NS = 100,
  // rising edges with reset held
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // released on a rising edge like every other input
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

/* verification/tb_analog_top.sv */
`timescale 1ns/100ps

module tb_analog_top import pitaya_pkg::*; ();

  localparam int N_ROWS = 10;
  localparam int DEB_LEN = 8;
  localparam int WDOG_CYCLES = N_ROWS * 40 + 2000;

  // settings, one cycle of stimulus, expected outputs
  typedef struct packed {
    logic wr;
    logic [NCH-1:0] loop;
    cal_t [NCH-1:0] adc_cal;
    cal_t [NCH-1:0] dac_cal;
    logic [NCH-1:0][ADC_RAW_W-1:0] raw;
    smp_stream_t dac;
    logic exp_vld;
    smp_t [NCH-1:0] exp_acq;
    logic [NCH-1:0][SMP_W-1:0] exp_dac;
  } row_t;

  logic adc_clk;
  logic top_rst;
  cfg_wr_t cfg;
  logic [NCH-1:0][ADC_RAW_W-1:0] adc_dat;
  smp_stream_t dac_smp;
  logic exp_pin;
  smp_stream_t acq;
  logic [NCH-1:0][SMP_W-1:0] dac_dat;
  logic dac_rst;
  trg_t trg;

  row_t rows [N_ROWS];
  int errors = 0;
  int checks = 0;

  clk_gen #(.PERIOD_NS (100), .RST_CYCLES (10)) clocks (.clk_o (adc_clk), .rst_o (top_rst));

  analog_top #(.DEB_CW (4), .DEB_LEN (DEB_LEN)) analog_top_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .cfg_i     (cfg),
    .adc_dat_i (adc_dat),
    .dac_i     (dac_smp),
    .exp_i     (exp_pin),
    .acq_o     (acq),
    .dac_dat_o (dac_dat),
    .dac_rst_o (dac_rst),
    .trg_o     (trg)
  );

  ////////////////////
  // reference model
  ////////////////////

  // code 0 is the top of the range with inverted slope
  function automatic int adc_value(input logic [ADC_RAW_W-1:0] raw);
    return SMP_MAX - int'(raw >> 2);
  endfunction

  // gain in units of 2^-14, then offset, then clamp
  function automatic int gain_offset(input int x, input cal_t c);
    int y;
    y = ((x * int'($signed(c.mul))) >>> GAIN_SHIFT) + int'($signed(c.sum));
    return (y > SMP_MAX) ? SMP_MAX : (y < SMP_MIN) ? SMP_MIN : y;
  endfunction

  // DAC slope runs the other way as well
  function automatic logic [SMP_W-1:0] dac_code(input int s);
    return SMP_W'(SMP_MAX - s);
  endfunction

  function automatic cal_t mk_cal(input int mul, input int sum);
    cal_t c;
    c = '0;
    c.mul = MUL_W'(mul);
    c.sum = SMP_W'(sum);
    return c;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", what, got, exp);
    end
  endtask

  ////////////////////
  // stimulus table
  ////////////////////

  task automatic build_table();
    logic [NCH-1:0][SMP_W-1:0] prev;
    int src;
    // unity settings and random samples
    for (int n = 0; n < N_ROWS; n++) begin
      rows[n] = '0;
      rows[n].wr = 1'b1;
      rows[n].dac.vld = 1'b1;
      for (int i = 0; i < NCH; i++) begin
        rows[n].adc_cal[i] = mk_cal(1 << GAIN_SHIFT, 0);
        rows[n].dac_cal[i] = mk_cal(1 << GAIN_SHIFT, 0);
        rows[n].raw[i] = ADC_RAW_W'($urandom);
        rows[n].dac.dat[i] = SMP_W'($urandom);
      end
    end
    // reset settings left alone
    rows[0].wr = 1'b0;
    rows[1].adc_cal = {mk_cal(24576, -200), mk_cal(8192, 100)};
    // full scale on both ends so both clamp
    rows[2].adc_cal = {mk_cal(32767, 0), mk_cal(32767, 0)};
    rows[2].raw = {16'hFFFF, 16'h0000};
    // inverted gain and an offset past the top
    rows[3].adc_cal = {mk_cal(16384, 8191), mk_cal(-16384, 0)};
    rows[3].raw[1] = 16'h0000;
    rows[4].dac_cal = {mk_cal(16384, 50), mk_cal(8192, -1000)};
    // no DAC sample so the word holds
    rows[5].dac.vld = 1'b0;
    rows[6].loop = 2'b01;
    rows[6].adc_cal = {mk_cal(12000, -5), mk_cal(16384, 10)};
    rows[6].dac_cal[0] = mk_cal(8192, 20);
    // looped channel without a DAC sample
    rows[7].loop = 2'b10;
    rows[7].dac.vld = 1'b0;
    // both looped with the DAC stage saturating
    rows[8].loop = 2'b11;
    rows[8].dac_cal = {mk_cal(32767, 0), mk_cal(32767, 0)};
    rows[8].dac.dat = {smp_t'(-8000), smp_t'(7000)};
    // expected values
    prev = '0;
    for (int n = 0; n < N_ROWS; n++) begin
      rows[n].exp_vld = (rows[n].loop != '0) ? rows[n].dac.vld : 1'b1;
      for (int i = 0; i < NCH; i++) begin
        src = rows[n].loop[i] ?
              gain_offset(int'($signed(rows[n].dac.dat[i])), rows[n].dac_cal[i]) :
              adc_value(rows[n].raw[i]);
        rows[n].exp_acq[i] = SMP_W'(gain_offset(src, rows[n].adc_cal[i]));
        if (rows[n].dac.vld) begin
          prev[i] = dac_code(gain_offset(int'($signed(rows[n].dac.dat[i])),
                                         rows[n].dac_cal[i]));
        end
      end
      rows[n].exp_dac = prev;
    end
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    cfg_wr_t w;
    w.en = 1'b1;
    w.addr = addr;
    w.data = data;
    @(posedge adc_clk);
    cfg <= w;
  endtask

  // random ADC words without a DAC sample
  task automatic idle_cycle();
    @(posedge adc_clk);
    cfg.en <= 1'b0;
    dac_smp.vld <= 1'b0;
    for (int i = 0; i < NCH; i++) begin
      adc_dat[i] <= ADC_RAW_W'($urandom);
      dac_smp.dat[i] <= SMP_W'($urandom);
    end
  endtask

  task automatic check_acq(input int n, input row_t r);
    compare($sformatf("row %0d acq_o.vld", n), 32'(acq.vld), 32'(r.exp_vld));
    if (r.exp_vld) begin
      for (int i = 0; i < NCH; i++) begin
        compare($sformatf("row %0d acq_o.dat[%0d]", n, i), 32'(acq.dat[i]), 32'(r.exp_acq[i]));
      end
    end
  endtask

  task automatic run_row(input int n);
    row_t r;
    ctl_t c;
    r = rows[n];
    if (r.wr) begin
      c = '0;
      c.loop = r.loop;
      write_reg(REG_CTL, c);
      for (int i = 0; i < NCH; i++) begin
        write_reg(REG_ADC_CAL0 + 4'(i), r.adc_cal[i]);
        write_reg(REG_DAC_CAL0 + 4'(i), r.dac_cal[i]);
      end
    end
    repeat (2) idle_cycle();
    // stimulus for one cycle only, so latency errors show
    @(posedge adc_clk);
    adc_dat <= r.raw;
    dac_smp <= r.dac;
    idle_cycle();
    // looped rows read the other channel one cycle later
    if (r.loop != '0) begin
      adc_dat <= r.raw;
    end
    repeat (2) idle_cycle();
    @(negedge adc_clk);
    for (int i = 0; i < NCH; i++) begin
      compare($sformatf("row %0d dac_dat_o[%0d]", n, i), 32'(dac_dat[i]), 32'(r.exp_dac[i]));
    end
    if (r.loop == '0) begin
      check_acq(n, r);
    end
    idle_cycle();
    @(negedge adc_clk);
    if (r.loop != '0) begin
      check_acq(n, r);
    end
  endtask

  ////////////////////
  // trigger
  ////////////////////

  // pin at lvl for hold cycles, then back, count pulses
  task automatic watch_trigger(input logic lvl, input int hold, input int pos_exp,
                               input int neg_exp);
    int pos_n;
    int neg_n;
    int first;
    pos_n = 0;
    neg_n = 0;
    first = -1;
    for (int i = 0; i < 3 * DEB_LEN; i++) begin
      @(posedge adc_clk);
      exp_pin <= (i < hold) ? lvl : ~lvl;
      @(negedge adc_clk);
      if ((trg.pos || trg.neg) && first < 0) begin
        first = i;
      end
      pos_n = pos_n + int'(trg.pos);
      neg_n = neg_n + int'(trg.neg);
    end
    compare($sformatf("trg_o.pos pulses, level %0b", lvl), pos_n, pos_exp);
    compare($sformatf("trg_o.neg pulses, level %0b", lvl), neg_n, neg_exp);
    if (first > DEB_LEN + 4) begin
      errors++;
      $display("trigger pulse came %0d cycles after the pin change, limit %0d",
               first, DEB_LEN + 4);
    end
  endtask

  initial begin
    void'($urandom(32'h9d957ea4));
    cfg <= '0;
    adc_dat <= '0;
    dac_smp <= '0;
    exp_pin <= 1'b0;
    build_table();
    @(negedge adc_clk);
    compare("acq_o.vld in reset", 32'(acq.vld), 0);
    compare("dac_dat_o in reset", 32'(dac_dat), 0);
    compare("dac_rst_o in reset", 32'(dac_rst), 1);
    compare("trg_o in reset", 32'(trg), 0);
    wait (top_rst == 1'b0);
    // DAC reset falls on the first edge and valid rises on the third
    // no DAC sample yet so the DAC word keeps its reset value
    for (int e = 0; e < 4; e++) begin
      @(negedge adc_clk);
      compare($sformatf("dac_rst_o %0d edges after release", e), 32'(dac_rst), 32'(e == 0));
      compare($sformatf("acq_o.vld %0d edges after release", e), 32'(acq.vld), 32'(e == 3));
      compare($sformatf("dac_dat_o %0d edges after release", e), 32'(dac_dat), 0);
    end
    for (int n = 0; n < N_ROWS; n++) begin
      run_row(n);
    end
    // short glitch, then a clean rise and fall
    watch_trigger(1'b1, DEB_LEN - 3, 0, 0);
    watch_trigger(1'b1, 3 * DEB_LEN, 1, 0);
    watch_trigger(1'b0, 3 * DEB_LEN, 0, 1);
    $display("errors %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WDOG_CYCLES) @(posedge adc_clk);
    $display("timeout: run still busy after %0d cycles", WDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* tb.f */
source/pitaya_pkg.sv
source/calib_regs.sv
source/linear_cal.sv
source/adc_frontend.sv
source/dac_backend.sv
source/gpio_debounce.sv
source/analog_top.sv
verification/clk_gen.sv
verification/tb_analog_top.sv

/* Makefile */
# Verilator build and run of the analog data path testbench

VERILATOR ?= verilator
TOP       ?= tb_analog_top
SEED      ?= 1
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
RUN_ARGS  ?= +verilator+seed+$(SEED)
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# status comes from a search of the output for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
